// ==== verilog.f ====
+incdir+design
design/interact_pkg.sv
design/shared_ram.sv
design/vram_arbiter.sv
design/cpu_bus_decoder.sv
design/video_fetch.sv
design/interact_core.sv
tb/interact_checker.sv
tb/tb_interact.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_interact
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_interact.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_interact import interact_pkg::*; ();

	localparam int max_ops = 128;
	localparam int op_write = 0;
	localparam int op_read = 1;
	localparam int op_pixels = 2;
	localparam int ready_limit = 200;
	localparam int rsp_limit = 200;
	localparam int pixel_limit = 20000;

	logic clk_sys;
	logic rst_n;
	logic cpu_valid;
	cpu_req_t cpu_req;
	logic cpu_ready;
	logic cpu_rsp_valid;
	logic [7:0] cpu_rdata;
	logic [7:0] keys;
	logic pix_valid;
	rgb_t pix_rgb;
	logic pix_ready;
	logic [7:0] exp_rdata;
	logic test_end;
	int test_num;
	int pix_count;
	int total_checks;
	int total_errors;

	// one row per operation with kind, cpu address, data and test id
	// data is the write byte, the expected read byte or a pixel count
	int op_kind [max_ops];
	logic [15:0] op_addr [max_ops];
	int op_data [max_ops];
	int op_test [max_ops];
	int op_len;
	int timeouts;
	int prev_test;
	integer seed = 32'h4759_db5f;
	logic [31:0] rnd;

	interact_core i_dut (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
		.cpu_rsp_valid(cpu_rsp_valid), .cpu_rdata(cpu_rdata), .keys(keys),
		.pix_valid(pix_valid), .pix_rgb(pix_rgb), .pix_ready(pix_ready)
	);

	interact_checker i_checker (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
		.cpu_rsp_valid(cpu_rsp_valid), .cpu_rdata(cpu_rdata), .keys(keys),
		.exp_rdata(exp_rdata), .pix_valid(pix_valid), .pix_rgb(pix_rgb),
		.pix_ready(pix_ready), .test_end(test_end), .test_num(test_num),
		.pix_count(pix_count), .total_checks(total_checks), .total_errors(total_errors)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// random back-pressure on the pixel stream
	always @(negedge clk_sys)
	begin
		rnd = $random(seed);
		pix_ready = rnd[0];
	end

	function automatic logic [7:0] frame_byte(input logic [15:0] a);
		return (a[7:0] * 8'h4B) ^ a[15:8] ^ 8'h96;
	endfunction

	task automatic add_op(input int kind, input logic [15:0] addr, input int data,
		input int test);
		op_kind[op_len] = kind;
		op_addr[op_len] = addr;
		op_data[op_len] = data;
		op_test[op_len] = test;
		op_len++;
	endtask

	task automatic build_table();
		logic [15:0] a;
		op_len = 0;
		add_op(op_write, 16'h4123, 8'h3C, 2);
		add_op(op_write, 16'h5555, 8'hA5, 2);
		add_op(op_write, 16'h7FFF, 8'h81, 2);
		add_op(op_read, 16'h4123, 8'h3C, 2);
		add_op(op_read, 16'h5555, 8'hA5, 2);
		add_op(op_read, 16'h7FFF, 8'h81, 2);
		// rom, write-only colour windows, upper half, keyboard row
		add_op(op_read, 16'h0000, 8'hFF, 3);
		add_op(op_read, 16'h0ABC, 8'hFF, 3);
		add_op(op_read, 16'h1000, 8'hFF, 3);
		add_op(op_read, 16'h1800, 8'hFF, 3);
		add_op(op_read, 16'h8000, 8'hFF, 3);
		add_op(op_read, 16'hC3A7, 8'hFF, 3);
		add_op(op_read, 16'h3800, 8'h5A, 3);
		// colour B bit 6 set, so value 2 gives half level
		add_op(op_write, 16'h1000, 8'h2E, 4);
		add_op(op_write, 16'h1800, 8'h59, 4);
		for (int i = 0; i < 64; i++)
		begin
			a = 16'h4000 + 16'(i);
			add_op(op_write, a, frame_byte(a), 4);
		end
		add_op(op_write, 16'h3000, 8'h01, 4);
		add_op(op_pixels, 16'h0000, 600, 4);
		// cpu traffic outside the frame while video runs
		add_op(op_write, 16'h4200, 8'h77, 5);
		add_op(op_read, 16'h4123, 8'h3C, 5);
		add_op(op_write, 16'h6A01, 8'hC9, 5);
		add_op(op_read, 16'h4200, 8'h77, 5);
		add_op(op_read, 16'h6A01, 8'hC9, 5);
		add_op(op_read, 16'h3800, 8'h5A, 5);
		add_op(op_pixels, 16'h0000, 100, 5);
		add_op(op_write, 16'h1800, 8'h0E, 6);
		add_op(op_pixels, 16'h0000, 300, 6);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!cpu_ready && n < ready_limit)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (!cpu_ready)
		begin
			$display("timeout: cpu_ready stayed low for %0d cycles", n);
			timeouts++;
		end
		// transfer happens on the rising edge in between
		@(negedge clk_sys);
	endtask

	task automatic wait_response();
		int n;
		n = 0;
		while (!cpu_rsp_valid && n < rsp_limit)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (!cpu_rsp_valid)
		begin
			$display("timeout: no read response after %0d cycles", n);
			timeouts++;
		end
	endtask

	task automatic wait_pixels(input int target);
		int n;
		n = 0;
		while (pix_count < target && n < pixel_limit)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (pix_count < target)
		begin
			$display("timeout: only %0d of %0d pixels arrived", pix_count, target);
			timeouts++;
		end
	endtask

	task automatic run_op(input int i);
		if (op_kind[i] == op_pixels)
			wait_pixels(pix_count + op_data[i]);
		else
		begin
			cpu_valid = 1'b1;
			cpu_req.we = (op_kind[i] == op_write);
			cpu_req.addr = op_addr[i];
			cpu_req.wdata = 8'(op_data[i]);
			exp_rdata = 8'(op_data[i]);
			wait_ready();
			cpu_valid = 1'b0;
			if (op_kind[i] == op_read)
				wait_response();
		end
	endtask

	task automatic mark_test_end(input int n);
		test_num = n;
		test_end = 1'b1;
		@(negedge clk_sys);
		test_end = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		cpu_valid = 1'b0;
		cpu_req = '0;
		keys = 8'h5A;
		pix_ready = 1'b0;
		exp_rdata = 8'h00;
		test_end = 1'b0;
		test_num = 1;
		timeouts = 0;
		build_table();
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		prev_test = 1;
		for (int i = 0; i < op_len; i++)
		begin
			if (op_test[i] != prev_test)
			begin
				mark_test_end(prev_test);
				prev_test = op_test[i];
			end
			run_op(i);
		end
		mark_test_end(prev_test);
		@(negedge clk_sys);
		$display("summary: %0d checks, %0d errors, %0d timeouts", total_checks,
			total_errors, timeouts);
		if (total_errors == 0 && timeouts == 0 && total_checks > 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/interact_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module interact_checker import interact_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire cpu_valid,
	input wire cpu_req_t cpu_req,
	input wire cpu_ready,
	input wire cpu_rsp_valid,
	input wire [7:0] cpu_rdata,
	input wire [7:0] keys,
	input wire [7:0] exp_rdata,
	input wire pix_valid,
	input wire rgb_t pix_rgb,
	input wire pix_ready,
	input wire test_end,
	input int test_num,
	output int pix_count,
	output int total_checks,
	output int total_errors
);

	logic [7:0] shadow [0:(1 << `IX_RAM_AW) - 1];
	palette_t pal = '0;
	palette_t pal_old = '0;
	logic video_en = 1'b0;
	logic started = 1'b0;
	logic rd_open = 1'b0;
	logic [7:0] rd_model;
	logic [7:0] rd_table;
	int grace = 0;
	int pix_idx = 0;
	int test_checks = 0;
	int test_errors = 0;

	initial
	begin
		pix_count = 0;
		total_checks = 0;
		total_errors = 0;
	end

	// value 0/1 take the low colour bits, 2/3 the high ones; odd values use colour B
	function automatic rgb_t expect_rgb(input logic [1:0] v, input palette_t p);
		logic [7:0] src;
		logic [2:0] bits;
		logic [7:0] level;
		rgb_t o;
		src = v[0] ? p.color_b : p.color_a;
		bits = v[1] ? src[5:3] : src[2:0];
		level = (v == 2'd2 && p.color_b[6]) ? 8'h7F : 8'hFF;
		o.r = bits[0] ? level : 8'h00;
		o.g = bits[1] ? level : 8'h00;
		o.b = bits[2] ? level : 8'h00;
		return o;
	endfunction

	function automatic logic [1:0] pixel_value(input int idx);
		logic [7:0] b;
		b = shadow[`IX_RAM_AW'(idx / 4)];
		return 2'(b >> (2 * (idx % 4)));
	endfunction

	task automatic report_error(input string what);
		$display("error: %s", what);
		test_errors++;
		total_errors++;
	endtask

	task automatic compare(input string name, input logic [23:0] got, input logic [23:0] exp);
		test_checks++;
		total_checks++;
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic check_pixel();
		logic [1:0] v;
		rgb_t want;
		v = pixel_value(pix_idx);
		want = expect_rgb(v, pal);
		if (!video_en)
			report_error("pixel delivered while video is off");
		else if (grace > 0 && pix_rgb !== want && pix_rgb === expect_rgb(v, pal_old))
		begin
			// unpacked before the colour write landed
			test_checks++;
			total_checks++;
		end
		else
			compare("pix_rgb", pix_rgb, want);
		if (grace > 0)
			grace--;
		pix_idx = (pix_idx + 1) % (`IX_FRAME_BYTES * 4);
		pix_count++;
	endtask

	task automatic observe_request();
		logic [15:0] a;
		a = cpu_req.addr;
		if (cpu_req.we && a[15:14] == 2'b01)
			shadow[a[`IX_RAM_AW-1:0]] = cpu_req.wdata;
		else if (cpu_req.we && a[15:14] == 2'b00)
		begin
			if (a[13:11] == `IX_IO_COLOR_A || a[13:11] == `IX_IO_COLOR_B)
			begin
				pal_old = pal;
				grace = video_en ? 4 : 0;
				if (a[13:11] == `IX_IO_COLOR_A)
					pal.color_a = cpu_req.wdata;
				else
					pal.color_b = cpu_req.wdata;
			end
			else if (a[13:11] == `IX_IO_MISC)
			begin
				// frame restarts at pixel 0 when video turns on
				if (cpu_req.wdata[0] && !video_en)
					pix_idx = 0;
				video_en = cpu_req.wdata[0];
			end
		end
		else if (!cpu_req.we)
		begin
			rd_open = 1'b1;
			rd_table = exp_rdata;
			if (a[15:14] == 2'b01)
				rd_model = shadow[a[`IX_RAM_AW-1:0]];
			else if (a[15:14] == 2'b00 && a[13:11] == `IX_IO_KEYS)
				rd_model = keys;
			else
				rd_model = `IX_UNMAPPED;
		end
	endtask

	task automatic close_test();
		if (test_checks == 0)
			report_error($sformatf("test %0d ran without any check", test_num));
		if (test_errors == 0)
			$display("test %0d passed, %0d checks", test_num, test_checks);
		else
			$display("test %0d failed, %0d errors in %0d checks", test_num, test_errors,
				test_checks);
		test_checks = 0;
		test_errors = 0;
	endtask

	always @(posedge clk_sys)
	begin
		if (rst_n)
		begin
			if (!started)
			begin
				// outputs straight after reset
				compare("cpu_rsp_valid", 24'(cpu_rsp_valid), 24'h0);
				compare("pix_valid", 24'(pix_valid), 24'h0);
				compare("cpu_ready", 24'(cpu_ready), 24'h1);
				started = 1'b1;
			end
			// the port stays closed until the read is answered
			if (rd_open && cpu_ready)
				report_error("cpu_ready high while a read is outstanding");
			if (cpu_rsp_valid)
			begin
				if (!rd_open)
					report_error("read response arrived with no read outstanding");
				else
				begin
					compare("cpu_rdata", 24'(cpu_rdata), 24'(rd_model));
					compare("cpu_rdata", 24'(cpu_rdata), 24'(rd_table));
				end
				rd_open = 1'b0;
			end
			if (pix_valid && pix_ready)
				check_pixel();
			if (cpu_valid && cpu_ready)
				observe_request();
			if (test_end)
				close_test();
		end
	end

endmodule

`default_nettype wire

// ==== design/interact_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module interact_core import interact_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire cpu_valid,
	input wire cpu_req_t cpu_req,
	output logic cpu_ready,
	output logic cpu_rsp_valid,
	output logic [7:0] cpu_rdata,
	input wire [7:0] keys,
	output logic pix_valid,
	output rgb_t pix_rgb,
	input wire pix_ready
);

	logic cpu_mem_valid;
	mem_req_t cpu_mem_req;
	logic cpu_mem_ready;
	logic cpu_mem_rsp_valid;
	logic vid_mem_valid;
	mem_req_t vid_mem_req;
	logic vid_mem_ready;
	logic vid_mem_rsp_valid;
	logic [7:0] mem_rdata;
	palette_t palette;
	logic video_on;
	logic ram_en;
	logic ram_we;
	logic [`IX_RAM_AW-1:0] ram_addr;
	logic [7:0] ram_wdata;

	cpu_bus_decoder i_decoder (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
		.cpu_rsp_valid(cpu_rsp_valid), .cpu_rdata(cpu_rdata), .keys(keys),
		.mem_valid(cpu_mem_valid), .mem_req(cpu_mem_req), .mem_ready(cpu_mem_ready),
		.mem_rsp_valid(cpu_mem_rsp_valid), .mem_rdata(mem_rdata),
		.palette(palette), .video_on(video_on)
	);

	video_fetch i_fetch (
		.clk_sys(clk_sys), .rst_n(rst_n), .video_on(video_on), .palette(palette),
		.mem_valid(vid_mem_valid), .mem_req(vid_mem_req), .mem_ready(vid_mem_ready),
		.mem_rsp_valid(vid_mem_rsp_valid), .mem_rdata(mem_rdata),
		.pix_valid(pix_valid), .pix_rgb(pix_rgb), .pix_ready(pix_ready)
	);

	vram_arbiter i_arbiter (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.vid_valid(vid_mem_valid), .vid_req(vid_mem_req), .vid_ready(vid_mem_ready),
		.vid_rsp_valid(vid_mem_rsp_valid),
		.cpu_valid(cpu_mem_valid), .cpu_req(cpu_mem_req), .cpu_ready(cpu_mem_ready),
		.cpu_rsp_valid(cpu_mem_rsp_valid),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
	);

	shared_ram i_ram (
		.clk_sys(clk_sys), .en(ram_en), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// ==== design/video_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module video_fetch import interact_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire video_on,
	input wire palette_t palette,
	output logic mem_valid,
	output mem_req_t mem_req,
	input wire mem_ready,
	input wire mem_rsp_valid,
	input wire [7:0] mem_rdata,
	output logic pix_valid,
	output rgb_t pix_rgb,
	input wire pix_ready
);

	localparam logic [`IX_RAM_AW-1:0] last_addr = `IX_RAM_AW'(`IX_FRAME_BYTES - 1);

	logic [`IX_RAM_AW-1:0] frame_addr;
	logic inflight;
	logic buf_full;
	logic [7:0] buf_byte;
	logic [7:0] sh_byte;
	logic [2:0] sh_cnt;
	logic out_free;
	logic shift_out;
	logic load;
	logic flush;

	function automatic rgb_t color_of(input logic [1:0] pix, input palette_t pal);
		logic [2:0] c;
		logic [7:0] lvl;
		rgb_t o;
		case (pix)
			2'd0: c = pal.color_a[2:0];
			2'd1: c = pal.color_b[2:0];
			2'd2: c = pal.color_a[5:3];
			default: c = pal.color_b[5:3];
		endcase
		// half intensity only for value 2
		lvl = (pix == 2'd2 && pal.color_b[6]) ? 8'h7F : 8'hFF;
		o.r = c[0] ? lvl : 8'h00;
		o.g = c[1] ? lvl : 8'h00;
		o.b = c[2] ? lvl : 8'h00;
		return o;
	endfunction

	// one read at a time and only into an empty buffer
	assign mem_valid = video_on & ~buf_full & ~inflight;
	assign mem_req = '{we: 1'b0, addr: frame_addr, wdata: 8'h00};

	assign out_free = ~pix_valid | pix_ready;
	assign shift_out = out_free & (sh_cnt != 3'd0);
	assign load = buf_full & ((sh_cnt == 3'd0) | ((sh_cnt == 3'd1) & shift_out));
	// wait for the read in flight before dropping the frame
	assign flush = ~video_on & ~inflight;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			frame_addr <= '0;
			inflight <= 1'b0;
			buf_full <= 1'b0;
			sh_cnt <= 3'd0;
			pix_valid <= 1'b0;
		end
		else
		begin
			inflight <= mem_valid & mem_ready;
			if (flush)
			begin
				frame_addr <= '0;
				buf_full <= 1'b0;
				sh_cnt <= 3'd0;
				pix_valid <= 1'b0;
			end
			else
			begin
				if (mem_valid && mem_ready)
					frame_addr <= (frame_addr == last_addr) ? '0 : frame_addr + 1'b1;
				if (mem_rsp_valid)
					buf_full <= 1'b1;
				else if (load)
					buf_full <= 1'b0;
				if (load)
					sh_cnt <= 3'd4;
				else if (shift_out)
					sh_cnt <= sh_cnt - 3'd1;
				if (shift_out)
					pix_valid <= 1'b1;
				else if (pix_ready)
					pix_valid <= 1'b0;
			end
		end
	end

	// lowest pixel pair leaves first
	always_ff @(posedge clk_sys)
	begin
		if (mem_rsp_valid)
			buf_byte <= mem_rdata;
		if (shift_out)
		begin
			pix_rgb <= color_of(sh_byte[1:0], palette);
			sh_byte <= sh_byte >> 2;
		end
		if (load)
			sh_byte <= buf_byte;
	end

	a_pix_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pix_valid && !pix_ready |=> $stable(pix_rgb));

endmodule

`default_nettype wire

// ==== design/cpu_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module cpu_bus_decoder import interact_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire cpu_valid,
	input wire cpu_req_t cpu_req,
	output logic cpu_ready,
	output logic cpu_rsp_valid,
	output logic [7:0] cpu_rdata,
	input wire [7:0] keys,
	output logic mem_valid,
	output mem_req_t mem_req,
	input wire mem_ready,
	input wire mem_rsp_valid,
	input wire [7:0] mem_rdata,
	output palette_t palette,
	output logic video_on
);

	logic accept;
	logic is_ram;
	logic is_io;
	logic [2:0] io_win;
	logic pending;
	logic io_rsp;
	logic [7:0] io_rdata;

	assign is_ram = ~cpu_req.addr[15] & cpu_req.addr[14];
	assign is_io = (cpu_req.addr[15:14] == 2'b00);
	assign io_win = cpu_req.addr[13:11];

	// no new request while a ram access is held or a read is open
	assign cpu_ready = ~pending & ~mem_valid;
	assign accept = cpu_valid & cpu_ready;

	assign cpu_rsp_valid = io_rsp | mem_rsp_valid;
	assign cpu_rdata = io_rsp ? io_rdata : mem_rdata;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pending <= 1'b0;
			mem_valid <= 1'b0;
			io_rsp <= 1'b0;
			palette <= '0;
			video_on <= 1'b0;
		end
		else
		begin
			if (accept && !cpu_req.we)
				pending <= 1'b1;
			else if (cpu_rsp_valid)
				pending <= 1'b0;

			// hold the ram request until the arbiter takes it
			if (accept && is_ram)
				mem_valid <= 1'b1;
			else if (mem_ready)
				mem_valid <= 1'b0;

			// io and unmapped reads answer one cycle later
			io_rsp <= accept & ~cpu_req.we & ~is_ram;

			if (accept && cpu_req.we && is_io)
			begin
				case (io_win)
					`IX_IO_COLOR_A: palette.color_a <= cpu_req.wdata;
					`IX_IO_COLOR_B: palette.color_b <= cpu_req.wdata;
					// misc bit 0 is the video enable
					`IX_IO_MISC: video_on <= cpu_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (accept && is_ram)
			mem_req <= '{we: cpu_req.we, addr: cpu_req.addr[`IX_RAM_AW-1:0],
				wdata: cpu_req.wdata};
		if (is_io && io_win == `IX_IO_KEYS)
			io_rdata <= keys;
		else
			io_rdata <= `IX_UNMAPPED;
	end

	a_rsp_pending: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cpu_rsp_valid |-> pending);

endmodule

`default_nettype wire

// ==== design/vram_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module vram_arbiter import interact_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire vid_valid,
	input wire mem_req_t vid_req,
	output logic vid_ready,
	output logic vid_rsp_valid,
	input wire cpu_valid,
	input wire mem_req_t cpu_req,
	output logic cpu_ready,
	output logic cpu_rsp_valid,
	output logic ram_en,
	output logic ram_we,
	output logic [`IX_RAM_AW-1:0] ram_addr,
	output logic [7:0] ram_wdata
);

	mem_req_t sel_req;

	// video always wins and the cpu only gets idle slots
	assign vid_ready = vid_valid;
	assign cpu_ready = cpu_valid & ~vid_valid;

	assign sel_req = vid_valid ? vid_req : cpu_req;

	assign ram_en = vid_ready | cpu_ready;
	assign ram_we = ram_en & sel_req.we;
	assign ram_addr = sel_req.addr;
	assign ram_wdata = sel_req.wdata;

	// remember who issued the read since the data is shared
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vid_rsp_valid <= 1'b0;
			cpu_rsp_valid <= 1'b0;
		end
		else
		begin
			vid_rsp_valid <= vid_ready & ~vid_req.we;
			cpu_rsp_valid <= cpu_ready & ~cpu_req.we;
		end
	end

	// a waiting cpu request stays put until it is granted
	a_cpu_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cpu_valid && !cpu_ready |=> cpu_valid && $stable(cpu_req));

	// the video client only reads
	a_vid_read: assert property (@(posedge clk_sys) disable iff (!rst_n)
		vid_valid |-> !vid_req.we);

endmodule

`default_nettype wire

// ==== design/shared_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "interact_macros.svh"

module shared_ram (
	input wire clk_sys,
	input wire en,
	input wire we,
	input wire [`IX_RAM_AW-1:0] addr,
	input wire [7:0] wdata,
	output logic [7:0] rdata
);

	// one byte per location on a single port
	logic [7:0] mem [0:(1 << `IX_RAM_AW) - 1];

	always_ff @(posedge clk_sys)
	begin
		if (en)
		begin
			if (we)
			begin
				mem[addr] <= wdata;
			end
			else
			begin
				// read data valid the cycle after en
				rdata <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/interact_pkg.sv ====
`default_nettype none

`include "interact_macros.svh"

package interact_pkg;

	// request into the shared ram arbiter
	typedef struct packed {
		logic we;
		logic [`IX_RAM_AW-1:0] addr;
		logic [7:0] wdata;
	} mem_req_t;

	// request on the external cpu port
	typedef struct packed {
		logic we;
		logic [15:0] addr;
		logic [7:0] wdata;
	} cpu_req_t;

	// colour registers handed to the fetcher
	typedef struct packed {
		logic [7:0] color_a;
		logic [7:0] color_b;
	} palette_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

`default_nettype wire

// ==== design/interact_macros.svh ====
`ifndef INTERACT_MACROS_SVH
`define INTERACT_MACROS_SVH

// ram address width for 16 KiB of shared video/work memory
`define IX_RAM_AW 14

// frame buffer length in bytes from ram offset 0 (cpu 4000h)
`define IX_FRAME_BYTES 64

// io window index from cpu address bits 13:11
`define IX_IO_COLOR_A 3'd2
`define IX_IO_COLOR_B 3'd3
`define IX_IO_MISC 3'd6
`define IX_IO_KEYS 3'd7

// read value for rom, write-only io and unmapped space
`define IX_UNMAPPED 8'hFF

`endif
